// File: include/xbar_consts.svh
// Width and size constants shared by the crossbar RTL and its testbench
// Include after `default_nettype in any file that needs these values

`ifndef XBAR_CONSTS_SVH
`define XBAR_CONSTS_SVH

// Flit payload width
`define XBAR_DATA_W 16

// Input and output port count
`define XBAR_PORTS 4

// Destination field, log2 of the port count
`define XBAR_DEST_W 2

// Delivered-flit counter width, saturates at all ones
`define XBAR_CNT_W 8

// Byte address width of the register block
`define AXIL_ADDR_W 8

`endif

// File: hdl/xbar_pkg.sv
// Flit types and arbiter state for the crossbar datapath
// Imported by the switch, the arbiter, the monitor and the top level

`default_nettype none

`include "xbar_consts.svh"

package xbar_pkg;

    // One flit as offered on an input or delivered on an output
    typedef struct packed {
        logic                    valid;
        logic [`XBAR_DEST_W-1:0] dest;
        logic [`XBAR_DATA_W-1:0] data;
    } flit_t;

    // One flit per port, index is the port number
    typedef flit_t [`XBAR_PORTS-1:0] flit_vec_t;

    // Whether the arbiter issued a grant in the previous cycle
    typedef enum logic {
        IDLE    = 1'b0,
        GRANTED = 1'b1
    } arb_state_e;

endpackage

`default_nettype wire

// File: hdl/axil_pkg.sv
// AXI4-Lite channel bundles and register map for the crossbar host port
// Imported by the register block and the top level

`default_nettype none

`include "xbar_consts.svh"

package axil_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

    // Host to slave
    typedef struct packed {
        logic [`AXIL_ADDR_W-1:0] awaddr;
        logic                    awvalid;
        logic [31:0]             wdata;
        logic [3:0]              wstrb;
        logic                    wvalid;
        logic                    bready;
        logic [`AXIL_ADDR_W-1:0] araddr;
        logic                    arvalid;
        logic                    rready;
    } axil_req_t;

    // Slave to host
    typedef struct packed {
        logic        awready;
        logic        wready;
        axil_resp_e  bresp;
        logic        bvalid;
        logic [31:0] rdata;
        axil_resp_e  rresp;
        logic        rvalid;
        logic        arready;
    } axil_rsp_t;

    // Register map, byte addresses
    typedef enum logic [`AXIL_ADDR_W-1:0] {
        REG_CTRL   = 8'h00,
        REG_STATUS = 8'h04,
        REG_CNT0   = 8'h10,
        REG_CNT1   = 8'h14,
        REG_CNT2   = 8'h18,
        REG_CNT3   = 8'h1C
    } csr_addr_e;

    typedef enum logic [1:0] {
        IDLE,
        WRESP,
        RDATA
    } csr_state_e;

endpackage

`default_nettype wire

// File: hdl/xbar_arbiter.sv
// Round-robin arbiter for one crossbar output
// Grant is combinational from req and the stored priority pointer

`default_nettype none

`include "xbar_consts.svh"

module xbar_arbiter
    import xbar_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst,
    input  wire [`XBAR_PORTS-1:0]   req,
    output logic [`XBAR_PORTS-1:0]  grant
);

    localparam int N  = `XBAR_PORTS;
    localparam int DW = `XBAR_DEST_W;

    // Last granted input
    logic [DW-1:0] ptr;
    logic [DW-1:0] idx;
    logic [DW-1:0] win;
    arb_state_e    state;

    // Scan from the farthest offset down so the nearest requester after ptr wins
    always_comb begin
        grant = '0;
        win   = ptr;
        idx   = ptr;
        for (int i = N; i >= 1; i--) begin
            idx = ptr + DW'(i);
            if (req[idx]) begin
                grant      = '0;
                grant[idx] = 1'b1;
                win        = idx;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // Input 0 goes first after reset
            ptr   <= DW'(N - 1);
            state <= IDLE;
        end else if (|grant) begin
            ptr   <= win;
            state <= GRANTED;
        end else begin
            state <= IDLE;
        end
    end

    assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
        else $error("xbar_arbiter: grant is not one-hot");

    // Last winner drops to lowest priority while others still request
    assert property (@(posedge clk) disable iff (rst)
        state == GRANTED && req[ptr] && $countones(req) > 1 |-> !grant[ptr])
        else $error("xbar_arbiter: last winner granted again ahead of others");

endmodule

`default_nettype wire

// File: hdl/xbar_switch.sv
// Crossbar switch fabric: per-output arbitration and registered outputs
// Ready toward the sources is combinational from the current grants

`default_nettype none

`include "xbar_consts.svh"

module xbar_switch
    import xbar_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst,
    input  wire flit_vec_t          in_flits,
    input  wire                     enable,
    output logic [`XBAR_PORTS-1:0]  in_ready,
    output flit_vec_t               out_flits,
    output logic                    busy
);

    localparam int N  = `XBAR_PORTS;
    localparam int DW = `XBAR_DEST_W;

    // Indexed [output][input]
    logic [N-1:0] req     [N];
    logic [N-1:0] grant   [N];
    // Indexed [input][output]
    logic [N-1:0] gnt_col [N];
    logic         any_valid;

    always_comb begin
        any_valid = 1'b0;
        for (int k = 0; k < N; k++) begin
            for (int j = 0; j < N; j++) begin
                req[k][j] = enable && in_flits[j].valid && (in_flits[j].dest == DW'(k));
                gnt_col[j][k] = grant[k][j];
            end
        end
        for (int j = 0; j < N; j++) begin
            in_ready[j] = |gnt_col[j];
            any_valid   = any_valid | in_flits[j].valid;
        end
    end

    for (genvar k = 0; k < N; k++) begin : g_out
        xbar_arbiter u_arb (
            .clk   (clk),
            .rst   (rst),
            .req   (req[k]),
            .grant (grant[k])
        );

        assert property (@(posedge clk) disable iff (rst)
            out_flits[k].valid |-> $past(|grant[k]))
            else $error("xbar_switch: output %0d valid without grant", k);
    end

    for (genvar j = 0; j < N; j++) begin : g_in
        assert property (@(posedge clk) disable iff (rst) $onehot0(gnt_col[j]))
            else $error("xbar_switch: input %0d granted by two outputs", j);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_flits <= '0;
            busy      <= 1'b0;
        end else begin
            busy <= any_valid;
            for (int k = 0; k < N; k++) begin
                // No grant means nothing delivered this cycle
                out_flits[k] <= '0;
                for (int j = 0; j < N; j++) begin
                    if (grant[k][j]) begin
                        out_flits[k] <= in_flits[j];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/xbar_traffic_monitor.sv
// Counts flits delivered on each crossbar output
// Counters saturate and can be cleared one at a time from the host

`default_nettype none

`include "xbar_consts.svh"

module xbar_traffic_monitor
    import xbar_pkg::*;
(
    input  wire                                        clk,
    input  wire                                        rst,
    input  wire flit_vec_t                             out_flits,
    input  wire [`XBAR_PORTS-1:0]                      clear,
    output logic [`XBAR_PORTS-1:0][`XBAR_CNT_W-1:0]    counts
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            counts <= '0;
        end else begin
            for (int k = 0; k < `XBAR_PORTS; k++) begin
                // Clear wins over a delivery in the same cycle
                if (clear[k]) begin
                    counts[k] <= '0;
                end else if (out_flits[k].valid && counts[k] != '1) begin
                    counts[k] <= counts[k] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/xbar_csr_axil.sv
// AXI4-Lite register block for the crossbar: enable, busy status, counters
// One transaction at a time, writes win over reads arriving together

`default_nettype none

`include "xbar_consts.svh"

module xbar_csr_axil
    import axil_pkg::*;
(
    input  wire                                        clk,
    input  wire                                        rst,
    input  wire axil_req_t                             axil_req,
    output axil_rsp_t                                  axil_rsp,
    input  wire                                        busy,
    input  wire [`XBAR_PORTS-1:0][`XBAR_CNT_W-1:0]     counts,
    output logic                                       enable,
    output logic [`XBAR_PORTS-1:0]                     cnt_clear
);

    csr_state_e  state;
    // AW and W accepted together in the cycle after both are seen
    logic        aw_acc;
    logic        ar_hs;
    axil_resp_e  bresp_q;
    axil_resp_e  rresp_q;
    axil_resp_e  rd_resp;
    logic [31:0] rdata_q;
    logic [31:0] rd_data;

    assign ar_hs = (state == IDLE) && !aw_acc && axil_req.arvalid
                   && !(axil_req.awvalid && axil_req.wvalid);

    // Read mux
    always_comb begin
        rd_data = '0;
        rd_resp = OKAY;
        case (csr_addr_e'(axil_req.araddr))
            REG_CTRL:   rd_data[0] = enable;
            REG_STATUS: rd_data[0] = busy;
            REG_CNT0, REG_CNT1, REG_CNT2, REG_CNT3:
                rd_data = 32'(counts[axil_req.araddr[3:2]]);
            default:    rd_resp = SLVERR;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            aw_acc    <= 1'b0;
            enable    <= 1'b0;
            cnt_clear <= '0;
            bresp_q   <= OKAY;
        end else begin
            cnt_clear <= '0;
            case (state)
                IDLE: begin
                    if (aw_acc) begin
                        aw_acc  <= 1'b0;
                        state   <= WRESP;
                        bresp_q <= OKAY;
                        case (csr_addr_e'(axil_req.awaddr))
                            REG_CTRL: begin
                                if (axil_req.wstrb[0]) begin
                                    enable <= axil_req.wdata[0];
                                end
                            end
                            REG_CNT0, REG_CNT1, REG_CNT2, REG_CNT3:
                                cnt_clear[axil_req.awaddr[3:2]] <= 1'b1;
                            // Status is read-only
                            default: bresp_q <= SLVERR;
                        endcase
                    end else if (axil_req.awvalid && axil_req.wvalid) begin
                        aw_acc <= 1'b1;
                    end else if (ar_hs) begin
                        state <= RDATA;
                    end
                end
                WRESP: if (axil_req.bready) state <= IDLE;
                RDATA: if (axil_req.rready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Read data captured at the AR handshake
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rdata_q <= rd_data;
            rresp_q <= rd_resp;
        end
    end

    always_comb begin
        axil_rsp.awready = aw_acc;
        axil_rsp.wready  = aw_acc;
        axil_rsp.bresp   = bresp_q;
        axil_rsp.bvalid  = (state == WRESP);
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = rresp_q;
        axil_rsp.rvalid  = (state == RDATA);
        axil_rsp.arready = ar_hs;
    end

    assert property (@(posedge clk) disable iff (rst)
        !(axil_rsp.bvalid && axil_rsp.rvalid))
        else $error("xbar_csr_axil: bvalid and rvalid both high");

endmodule

`default_nettype wire

// File: hdl/xbar_top.sv
// Crossbar top level: switch fabric, traffic monitor and host register block
// Flit ports face the sources and sinks, the AXI4-Lite port faces the host

`default_nettype none

`include "xbar_consts.svh"

module xbar_top
    import xbar_pkg::*, axil_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst,
    input  wire flit_vec_t          in_flits,
    output logic [`XBAR_PORTS-1:0]  in_ready,
    output flit_vec_t               out_flits,
    input  wire axil_req_t          axil_req,
    output axil_rsp_t               axil_rsp
);

    logic                                   enable;
    logic                                   busy;
    logic [`XBAR_PORTS-1:0]                 cnt_clear;
    logic [`XBAR_PORTS-1:0][`XBAR_CNT_W-1:0] counts;

    xbar_switch u_switch (
        .clk       (clk),
        .rst       (rst),
        .in_flits  (in_flits),
        .enable    (enable),
        .in_ready  (in_ready),
        .out_flits (out_flits),
        .busy      (busy)
    );

    // Watches the registered outputs, so counts lag delivery by one cycle
    xbar_traffic_monitor u_monitor (
        .clk       (clk),
        .rst       (rst),
        .out_flits (out_flits),
        .clear     (cnt_clear),
        .counts    (counts)
    );

    xbar_csr_axil u_csr (
        .clk       (clk),
        .rst       (rst),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .busy      (busy),
        .counts    (counts),
        .enable    (enable),
        .cnt_clear (cnt_clear)
    );

endmodule

`default_nettype wire

// File: test/xbar_tb.sv
// Testbench for the crossbar top level, driven by the steps in test/xbar_cases.txt
// Each step sends flits on the four inputs or makes one AXI4-Lite register access

`default_nettype none

`include "xbar_consts.svh"

module xbar_tb
    import xbar_pkg::*, axil_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // Cycles a SEND waits for its flits before it gives up
    localparam int SEND_WAIT = 8;

    logic                   clk;
    logic                   rst;
    flit_vec_t              in_flits;
    logic [`XBAR_PORTS-1:0] in_ready;
    flit_vec_t              out_flits;
    axil_req_t              axil_req;
    axil_rsp_t              axil_rsp;

    int    errors;
    int    cycles;
    int    cycle_limit;
    string lines [$];

    xbar_top DUT (
        .clk       (clk),
        .rst       (rst),
        .in_flits  (in_flits),
        .in_ready  (in_ready),
        .out_flits (out_flits),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit != 0 && cycles > cycle_limit) begin
            $display("Timeout: the run went past %0d cycles", cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    // Drives four flits, drops each one after its transfer and logs every delivered flit
    task automatic run_send(input string name, input string line, output bit ok);
        string                   skip;
        logic [31:0]             col [8];
        int                      n;
        int                      n_acc;
        bit                      pending;
        logic [`XBAR_PORTS-1:0]  acc;
        logic [`XBAR_DEST_W-1:0] port;
        logic [18:0]             got [$];
        ok = 1'b1;
        n_acc = 0;
        void'($sscanf(line, "%s %s %h %h %h %h %d %h %h %h %h", skip, skip, col[0], col[1],
                      col[2], col[3], n, col[4], col[5], col[6], col[7]));
        @(negedge clk);
        for (int j = 0; j < `XBAR_PORTS; j++) begin
            in_flits[j] = flit_t'(col[j][$bits(flit_t)-1:0]);
        end
        for (int c = 0; c < SEND_WAIT; c++) begin
            // Ready settles after the new inputs and holds until the rising edge
            #1;
            for (int j = 0; j < `XBAR_PORTS; j++) begin
                acc[j] = in_flits[j].valid && in_ready[j];
            end
            @(negedge clk);
            for (int k = 0; k < `XBAR_PORTS; k++) begin
                port = k[`XBAR_DEST_W-1:0];
                if (out_flits[k].valid) begin
                    got.push_back({1'b1, port, out_flits[k].data});
                    // A routed flit keeps the dest of the output it arrives on
                    if (out_flits[k].dest != port) begin
                        $display("CHECK FAILED %s: output %0d dest expected %0d, got %0d",
                                 name, k, port, out_flits[k].dest);
                        ok = 1'b0;
                    end
                end
            end
            pending = 1'b0;
            for (int j = 0; j < `XBAR_PORTS; j++) begin
                if (acc[j]) begin
                    in_flits[j] = '0;
                    n_acc++;
                end
                pending = pending | in_flits[j].valid;
            end
            if (!pending) break;
        end
        if (n_acc != n) begin
            $display("CHECK FAILED %s: expected %0d accepted flits, got %0d", name, n, n_acc);
            ok = 1'b0;
        end
        if (got.size() != n) begin
            $display("CHECK FAILED %s: expected %0d output flits, got %0d", name, n, got.size());
            ok = 1'b0;
        end
        for (int i = 0; i < n && i < got.size(); i++) begin
            if (got[i] != col[4+i][18:0]) begin
                $display("CHECK FAILED %s: flit %0d expected %h, got %h",
                         name, i, col[4+i][18:0], got[i]);
                ok = 1'b0;
            end
        end
    endtask

    // One AXI4-Lite write or read with its response and read data checked
    task automatic run_axil(input string name, input bit is_write, input string line,
                            output bit ok);
        string       skip;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] resp;
        logic [31:0] got_data;
        logic [1:0]  got_resp;
        bit          hs;
        ok = 1'b1;
        hs = 1'b0;
        void'($sscanf(line, "%s %s %h %h %h", skip, skip, addr, data, resp));
        @(negedge clk);
        if (is_write) begin
            axil_req.awaddr  = addr[`AXIL_ADDR_W-1:0];
            axil_req.wdata   = data;
            axil_req.wstrb   = 4'hF;
            axil_req.awvalid = 1'b1;
            axil_req.wvalid  = 1'b1;
            axil_req.bready  = 1'b1;
            while (!axil_rsp.awready) @(negedge clk);
            @(negedge clk);
            axil_req.awvalid = 1'b0;
            axil_req.wvalid  = 1'b0;
            while (!axil_rsp.bvalid) @(negedge clk);
            got_resp = axil_rsp.bresp;
            @(negedge clk);
            axil_req.bready = 1'b0;
        end else begin
            axil_req.araddr  = addr[`AXIL_ADDR_W-1:0];
            axil_req.arvalid = 1'b1;
            axil_req.rready  = 1'b1;
            // arready is combinational, so look after the inputs settle
            while (!hs) begin
                #1;
                hs = axil_rsp.arready;
                @(negedge clk);
            end
            axil_req.arvalid = 1'b0;
            while (!axil_rsp.rvalid) @(negedge clk);
            got_data = axil_rsp.rdata;
            got_resp = axil_rsp.rresp;
            @(negedge clk);
            axil_req.rready = 1'b0;
        end
        if (got_resp != resp[1:0]) begin
            $display("CHECK FAILED %s: resp expected %0d, got %0d", name, resp[1:0], got_resp);
            ok = 1'b0;
        end
        if (!is_write && got_data != data) begin
            $display("CHECK FAILED %s: rdata expected %h, got %h", name, data, got_data);
            ok = 1'b0;
        end
    endtask

    initial begin
        int    fd;
        string line;
        string name;
        string op;
        bit    ok;
        clk         = 1'b0;
        rst         = 1'b1;
        in_flits    = '0;
        axil_req    = '0;
        errors      = 0;
        cycles      = 0;
        cycle_limit = 0;
        void'($urandom(37145));
        fd = $fopen("test/xbar_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the case file test/xbar_cases.txt");
            errors++;
        end else begin
            // Skip comment lines and blank lines
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
        cycle_limit = lines.size() * 40 + 50;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (lines[i]) begin
            void'($sscanf(lines[i], "%s %s", name, op));
            ok = 1'b1;
            if (op == "SEND") begin
                run_send(name, lines[i], ok);
            end else if (op == "AXW" || op == "AXR") begin
                run_axil(name, op == "AXW", lines[i], ok);
            end else begin
                $display("Unknown operation %s in step %s", op, name);
                ok = 1'b0;
            end
            if (ok) begin
                $display("PASS %s", name);
            end else begin
                $display("FAIL %s", name);
                errors++;
            end
            repeat ($urandom % 4) @(negedge clk);
        end
        $display("Steps run: %0d, failed: %0d", lines.size(), errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/xbar_cases.txt
# name SEND in0 in1 in2 in3 count out0 out1 out2 out3, flit words are hex {valid, dest or port, data}
# name AXW addr wdata resp or name AXR addr rdata resp, resp 0 is OKAY and 2 is SLVERR
send_disabled  SEND 4A000 5A001 6A002 7A003 0 00000 00000 00000 00000
status_busy    AXR 04 00000001 0
ctrl_reset     AXR 00 00000000 0
drop_inputs    SEND 00000 00000 00000 00000 0 00000 00000 00000 00000
status_write   AXW 04 00000001 2
unmapped_read  AXR 30 00000000 2
enable_on      AXW 00 00000001 0
ctrl_on        AXR 00 00000001 0
send_distinct  SEND 51111 42222 73333 64444 4 42222 51111 64444 73333
fan_in_round1  SEND 60100 60101 60102 60103 4 60100 60101 60102 60103
fan_in_round2  SEND 60200 60201 60202 60203 4 60200 60201 60202 60203
cnt0_read      AXR 10 00000001 0
cnt1_read      AXR 14 00000001 0
cnt2_read      AXR 18 00000009 0
cnt3_read      AXR 1C 00000001 0
cnt2_clear     AXW 18 00000000 0
cnt2_cleared   AXR 18 00000000 0
cnt0_kept      AXR 10 00000001 0
cnt1_kept      AXR 14 00000001 0
cnt3_kept      AXR 1C 00000001 0
status_idle    AXR 04 00000000 0
ctrl_off       AXW 00 00000000 0
ctrl_off_read  AXR 00 00000000 0

// File: vlog.f
+incdir+include
hdl/xbar_pkg.sv
hdl/axil_pkg.sv
hdl/xbar_arbiter.sv
hdl/xbar_switch.sv
hdl/xbar_traffic_monitor.sv
hdl/xbar_csr_axil.sv
hdl/xbar_top.sv
test/xbar_tb.sv

// File: Bender.yml
package:
  name: xbar

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/xbar_pkg.sv
      - hdl/axil_pkg.sv
      - hdl/xbar_arbiter.sv
      - hdl/xbar_switch.sv
      - hdl/xbar_traffic_monitor.sv
      - hdl/xbar_csr_axil.sv
      - hdl/xbar_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/xbar_tb.sv
